//--- list.f
issue_pkg.sv
alu_op_decoder.sv
mem_op_decoder.sv
flow_op_decoder.sv
system_op_decoder.sv
issue_decoder.sv
issue_checker.sv
tb_issue_decoder.sv

//--- tb_issue_decoder.sv
// ========================================
// Testbench top for the issue decoder
// Drives legal, near-miss and random words from an xorshift source
// and reports the result of the checker
// ========================================
`timescale 1ns/1ps

module tb_issue_decoder;
    import issue_pkg::*;

    localparam int NUM_WORDS    = 2000;
    localparam int RESET_CYCLES = 2;
    // One word per cycle, plus reset, drain and slack
    localparam int MAX_CYCLES   = NUM_WORDS + 100;

    logic            clk;
    logic            rst_n_i;
    logic [ILEN-1:0] instruction;
    logic            except_raised;
    logic [3:0]      except_code;
    logic            res_ready;
    logic            stall_possible;
    logic [2:0]      eu;
    logic [7:0]      eu_ctl;
    logic            rs1_req;
    logic            rs2_req;
    logic            imm_req;
    logic            imm_format;
    logic            regstat_upd;
    logic [31:0]     error_count;
    logic [31:0]     check_count;
    logic [31:0]     rng_state;
    int              cycle_count;

    issue_decoder i_issue_decoder (
        .issue_instruction_i    (instruction),
        .issue_except_raised_o  (except_raised),
        .issue_except_code_o    (except_code),
        .issue_res_ready_o      (res_ready),
        .issue_stall_possible_o (stall_possible),
        .issue_eu_o             (eu),
        .issue_eu_ctl_o         (eu_ctl),
        .issue_rs1_req_o        (rs1_req),
        .issue_rs2_req_o        (rs2_req),
        .issue_imm_req_o        (imm_req),
        .issue_imm_format_o     (imm_format),
        .issue_regstat_upd_o    (regstat_upd)
    );

    issue_checker i_issue_checker (
        .clk_i            (clk),
        .rst_n_i          (rst_n_i),
        .instruction_i    (instruction),
        .except_raised_i  (except_raised),
        .except_code_i    (except_code),
        .res_ready_i      (res_ready),
        .stall_possible_i (stall_possible),
        .eu_i             (eu),
        .eu_ctl_i         (eu_ctl),
        .rs1_req_i        (rs1_req),
        .rs2_req_i        (rs2_req),
        .imm_req_i        (imm_req),
        .imm_format_i     (imm_format),
        .regstat_upd_i    (regstat_upd),
        .error_count_o    (error_count),
        .check_count_o    (check_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task draw_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // Template index 0..15, free fields come from r, choices from r2
    function automatic logic [31:0] build_legal(input logic [3:0] sel, input logic [31:0] r,
                                                input logic [31:0] r2);
        logic [31:0] w;
        logic [2:0]  f3;
        logic [2:0]  word_f3;
        w = r;
        f3 = r[14:12];
        word_f3 = (r2[2:1] == 2'd0) ? 3'd0 : ((r2[2:1] == 2'd1) ? 3'd1 : 3'd5);
        case (sel)
            4'd0: begin
                w[6:0]   = OP;
                w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && r2[0]) ? 7'b0100000 : 7'b0000000;
            end
            4'd1: begin
                w[6:0]   = OP_32;
                w[14:12] = word_f3;
                w[31:25] = ((word_f3 != 3'd1) && r2[0]) ? 7'b0100000 : 7'b0000000;
            end
            4'd2: w[6:0] = OP_IMM;
            4'd3: begin
                w[6:0]   = OP_IMM_32;
                w[14:12] = word_f3;
            end
            4'd4: begin
                w[6:0]   = LOAD;
                w[14:12] = (f3 == 3'd7) ? 3'd3 : f3;
            end
            4'd5: begin
                w[6:0] = STORE;
                w[14]  = 1'b0;
            end
            4'd6: begin
                w[6:0] = BRANCH;
                // Reserved codes 2 and 3 become 6 and 7
                w[14]  = w[14] | (f3[2:1] == 2'b01);
            end
            4'd7: w[6:0] = JAL;
            4'd8: begin
                w[6:0]   = JALR;
                w[14:12] = 3'd0;
            end
            4'd9:  w[6:0] = LUI;
            4'd10: w[6:0] = AUIPC;
            4'd11: begin
                w[6:0] = SYSTEM;
                w[12]  = w[12] | (f3[1:0] == 2'b00);
            end
            4'd12: begin
                w = {12'h000, 13'd0, SYSTEM};
                case (r2[5:3])
                    3'd0:    w[31:20] = 12'h000;
                    3'd1:    w[31:20] = 12'h001;
                    3'd2:    w[31:20] = 12'h102;
                    3'd3:    w[31:20] = 12'h105;
                    default: w[31:20] = 12'h302;
                endcase
            end
            4'd13: begin
                w[6:0]   = SYSTEM;
                w[14:7]  = 8'd0;
                w[31:25] = 7'b0001001;
            end
            4'd14: begin
                w[6:0]   = MISC_MEM;
                w[19:7]  = 13'd0;
                w[31:28] = 4'd0;
            end
            default: w = {17'd0, 3'd1, 5'd0, MISC_MEM};
        endcase
        return w;
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] r3;
        clk = 1'b0;
        rst_n_i = 1'b0;
        instruction = '0;
        cycle_count = 0;
        rng_state = 32'd28874;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int n = 0; n < NUM_WORDS; n++) begin
            draw_random(r);
            draw_random(r2);
            draw_random(r3);
            @(posedge clk);
            case (r3[2:0])
                3'd0: instruction <= r;
                // System pattern with one fixed-field bit flipped
                3'd1: instruction <= build_legal({2'b11, r3[4:3]}, r, r2) ^
                                     (32'h1 << (7 + r3[12:8] % 25));
                default: instruction <= build_legal(r3[6:3], r, r2);
            endcase
        end

        // Let the checker sample the last word
        repeat (2) @(posedge clk);
        #1;
        $display("Errors: %0d, words checked: %0d", error_count, check_count);
        if (error_count == 0 && check_count >= NUM_WORDS) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- issue_checker.sv
// ========================================
// Reference model and comparator for the issue decoder
// Decodes the applied word on each clock edge and compares all outputs
// ========================================
`timescale 1ns/1ps

module issue_checker (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic [issue_pkg::ILEN-1:0] instruction_i,
    input  logic                       except_raised_i,
    input  logic [3:0]                 except_code_i,
    input  logic                       res_ready_i,
    input  logic                       stall_possible_i,
    input  logic [2:0]                 eu_i,
    input  logic [7:0]                 eu_ctl_i,
    input  logic                       rs1_req_i,
    input  logic                       rs2_req_i,
    input  logic                       imm_req_i,
    input  logic                       imm_format_i,
    input  logic                       regstat_upd_i,
    output logic [31:0]                error_count_o,
    output logic [31:0]                check_count_o
);
    import issue_pkg::*;

    logic       exp_raised;
    logic [3:0] exp_code;
    logic       exp_ready;
    logic       exp_stall;
    logic [2:0] exp_eu;
    logic [7:0] exp_ctl;
    logic       exp_rs1;
    logic       exp_rs2;
    logic       exp_imm;
    logic       exp_fmt;
    logic       exp_regstat;

    // alt is SUB or the arithmetic shift
    function automatic logic [7:0] alu_op_for(input logic [2:0] f3, input logic alt,
                                              input logic word_op);
        case (f3)
            3'd0:    return alt ? (word_op ? SUBW : SUB) : (word_op ? ADDW : ADD);
            3'd1:    return word_op ? SLLW : SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return alt ? (word_op ? SRAW : SRA) : (word_op ? SRLW : SRL);
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic logic [7:0] width_for(input logic [2:0] f3);
        case (f3)
            3'd0:    return LS_BYTE;
            3'd1:    return LS_HALFWORD;
            3'd2:    return LS_WORD;
            3'd3:    return LS_DOUBLEWORD;
            3'd4:    return LS_BYTE_U;
            3'd5:    return LS_HALFWORD_U;
            default: return LS_WORD_U;
        endcase
    endfunction

    // Only called for the six defined branch codes
    function automatic logic [7:0] cond_for(input logic [2:0] f3);
        case (f3)
            3'd0:    return BEQ;
            3'd1:    return BNE;
            3'd4:    return BLT;
            3'd5:    return BGE;
            3'd6:    return BLTU;
            default: return BGEU;
        endcase
    endfunction

    task automatic predict(input logic [31:0] w);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic        word_op;
        logic        word_f3_ok;
        logic        low_clear;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        imm12 = w[31:20];
        word_op = (opc == OP_32) || (opc == OP_IMM_32);
        word_f3_ok = !word_op || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5;
        // rs1 and rd both zero
        low_clear = (w[19:15] == 5'd0) && (w[11:7] == 5'd0);

        // Illegal unless a rule below matches
        exp_raised = 1'b1;
        exp_code = E_ILLEGAL_INSTRUCTION;
        exp_ready = 1'b0;
        exp_stall = 1'b0;
        exp_eu = EU_NONE;
        exp_ctl = 8'd0;
        exp_rs1 = 1'b0;
        exp_rs2 = 1'b0;
        exp_imm = 1'b0;
        exp_fmt = IMM_SEXT;
        exp_regstat = 1'b0;

        case (opc)
            OP, OP_32: begin
                if (word_f3_ok && (f7 == 7'b0000000 ||
                    (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5)))) begin
                    exp_eu = EU_INT_ALU;
                    exp_ctl = alu_op_for(f3, f7[5], word_op);
                    exp_rs1 = 1'b1;
                    exp_rs2 = 1'b1;
                    exp_regstat = 1'b1;
                end
            end
            OP_IMM, OP_IMM_32: begin
                if (word_f3_ok) begin
                    exp_eu = EU_INT_ALU;
                    exp_ctl = alu_op_for(f3, w[30] && (f3 == 3'd5), word_op);
                    exp_rs1 = 1'b1;
                    exp_imm = 1'b1;
                    exp_fmt = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_SEXT;
                    exp_regstat = 1'b1;
                end
            end
            LOAD, STORE: begin
                if ((opc == LOAD && f3 != 3'd7) || (opc == STORE && !f3[2])) begin
                    exp_eu = (opc == LOAD) ? EU_LOAD_BUFFER : EU_STORE_BUFFER;
                    exp_ctl = width_for(f3);
                    exp_rs1 = 1'b1;
                    exp_rs2 = (opc == STORE);
                    exp_imm = 1'b1;
                    exp_regstat = (opc == LOAD);
                end
            end
            BRANCH: begin
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    exp_eu = EU_BRANCH_UNIT;
                    exp_ctl = cond_for(f3);
                    exp_rs1 = 1'b1;
                    exp_rs2 = 1'b1;
                    exp_imm = 1'b1;
                end
            end
            JAL, JALR, LUI, AUIPC: begin
                if (opc != JALR || f3 == 3'd0) begin
                    exp_imm = 1'b1;
                    exp_ready = 1'b1;
                    exp_stall = (opc == JALR);
                    exp_regstat = 1'b1;
                end
            end
            MISC_MEM: begin
                if (low_clear && ((f3 == 3'd0 && w[31:28] == 4'd0) ||
                    (f3 == 3'd1 && imm12 == 12'h000))) begin
                    exp_ready = 1'b1;
                    exp_stall = 1'b1;
                end
            end
            SYSTEM: begin
                if (f3 != 3'd0 && f3 != 3'd4) begin
                    exp_ready = 1'b1;
                    exp_stall = 1'b1;
                    exp_regstat = 1'b1;
                end else if (f3 == 3'd0 && low_clear && imm12 == 12'h001) begin
                    exp_code = E_BREAKPOINT;
                    exp_stall = 1'b1;
                end else if (f3 == 3'd0 && ((low_clear && (imm12 == 12'h000 ||
                    imm12 == 12'h102 || imm12 == 12'h105 || imm12 == 12'h302)) ||
                    (f7 == 7'b0001001 && w[11:7] == 5'd0))) begin
                    exp_ready = 1'b1;
                    exp_stall = 1'b1;
                end
            end
            default: ;
        endcase

        if (exp_code != E_ILLEGAL_INSTRUCTION || exp_eu != EU_NONE || exp_imm || exp_stall) begin
            exp_raised = (exp_code == E_BREAKPOINT);
            exp_code = exp_raised ? E_BREAKPOINT : E_UNKNOWN;
        end
    endtask

    task automatic compare_field(input string name, input logic [7:0] got,
                                 input logic [7:0] exp);
        if (got !== exp) begin
            error_count_o = error_count_o + 1;
            $display("CHECK FAILED at %0t: word %08h, %s is %0h, expected %0h",
                     $time, instruction_i, name, got, exp);
        end
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            error_count_o = 0;
            check_count_o = 0;
        end else begin
            predict(instruction_i);
            check_count_o = check_count_o + 1;
            compare_field("except_raised", except_raised_i, exp_raised);
            compare_field("except_code", except_code_i, exp_code);
            compare_field("res_ready", res_ready_i, exp_ready);
            compare_field("stall_possible", stall_possible_i, exp_stall);
            compare_field("eu", eu_i, exp_eu);
            compare_field("eu_ctl", eu_ctl_i, exp_ctl);
            compare_field("rs1_req", rs1_req_i, exp_rs1);
            compare_field("rs2_req", rs2_req_i, exp_rs2);
            compare_field("imm_req", imm_req_i, exp_imm);
            compare_field("imm_format", imm_format_i, exp_fmt);
            compare_field("regstat_upd", regstat_upd_i, exp_regstat);
        end
    end

endmodule

//--- issue_decoder.sv
// ========================================
// Issue-stage instruction decoder, top level
// Selects the class decoder that matches the word
// Words no class accepts raise illegal-instruction
// ========================================
`timescale 1ns/1ps

module issue_decoder (
    input  logic [issue_pkg::ILEN-1:0] issue_instruction_i,
    output logic                       issue_except_raised_o,
    output issue_pkg::except_code_t    issue_except_code_o,
    output logic                       issue_res_ready_o,
    output logic                       issue_stall_possible_o,
    output issue_pkg::issue_eu_t       issue_eu_o,
    output issue_pkg::eu_ctl_t         issue_eu_ctl_o,
    output logic                       issue_rs1_req_o,
    output logic                       issue_rs2_req_o,
    output logic                       issue_imm_req_o,
    output issue_pkg::imm_format_t     issue_imm_format_o,
    output logic                       issue_regstat_upd_o
);
    import issue_pkg::*;

    logic         alu_hit;
    alu_ctl_t     alu_ctl;
    logic         alu_rs2_req;
    imm_format_t  alu_imm_format;
    logic         mem_hit;
    logic         mem_store;
    ls_ctl_t      mem_ctl;
    logic         flow_hit;
    issue_eu_t    flow_eu;
    bu_ctl_t      flow_ctl;
    logic         flow_rs1_req;
    logic         flow_rs2_req;
    logic         flow_res_ready;
    logic         flow_stall_possible;
    logic         flow_regstat_upd;
    logic         sys_hit;
    logic         sys_regstat_upd;
    logic         sys_res_ready;
    logic         sys_except_raised;
    except_code_t sys_except_code;

    alu_op_decoder i_alu_op_decoder (
        .issue_instruction_i (issue_instruction_i),
        .alu_hit_o           (alu_hit),
        .alu_ctl_o           (alu_ctl),
        .alu_rs2_req_o       (alu_rs2_req),
        .alu_imm_format_o    (alu_imm_format)
    );

    mem_op_decoder i_mem_op_decoder (
        .issue_instruction_i (issue_instruction_i),
        .mem_hit_o           (mem_hit),
        .mem_store_o         (mem_store),
        .mem_ctl_o           (mem_ctl)
    );

    flow_op_decoder i_flow_op_decoder (
        .issue_instruction_i   (issue_instruction_i),
        .flow_hit_o            (flow_hit),
        .flow_eu_o             (flow_eu),
        .flow_ctl_o            (flow_ctl),
        .flow_rs1_req_o        (flow_rs1_req),
        .flow_rs2_req_o        (flow_rs2_req),
        .flow_res_ready_o      (flow_res_ready),
        .flow_stall_possible_o (flow_stall_possible),
        .flow_regstat_upd_o    (flow_regstat_upd)
    );

    system_op_decoder i_system_op_decoder (
        .issue_instruction_i (issue_instruction_i),
        .sys_hit_o           (sys_hit),
        .sys_regstat_upd_o   (sys_regstat_upd),
        .sys_res_ready_o     (sys_res_ready),
        .sys_except_raised_o (sys_except_raised),
        .sys_except_code_o   (sys_except_code)
    );

    // Classes are disjoint, so the order of the checks is arbitrary
    always_comb begin
        issue_except_raised_o  = 1'b0;
        issue_except_code_o    = E_UNKNOWN;
        issue_res_ready_o      = 1'b0;
        issue_stall_possible_o = 1'b0;
        issue_eu_o             = EU_NONE;
        issue_eu_ctl_o         = '0;
        issue_rs1_req_o        = 1'b0;
        issue_rs2_req_o        = 1'b0;
        issue_imm_req_o        = 1'b0;
        issue_imm_format_o     = IMM_SEXT;
        issue_regstat_upd_o    = 1'b0;

        if (alu_hit) begin
            issue_eu_o             = EU_INT_ALU;
            issue_eu_ctl_o.alu     = alu_ctl;
            issue_rs1_req_o        = 1'b1;
            issue_rs2_req_o        = alu_rs2_req;
            issue_imm_req_o        = !alu_rs2_req;
            issue_imm_format_o     = alu_imm_format;
            issue_regstat_upd_o    = 1'b1;
        end else if (mem_hit) begin
            issue_eu_o             = mem_store ? EU_STORE_BUFFER : EU_LOAD_BUFFER;
            issue_eu_ctl_o.ls      = mem_ctl;
            issue_rs1_req_o        = 1'b1;
            issue_rs2_req_o        = mem_store;
            issue_imm_req_o        = 1'b1;
            issue_regstat_upd_o    = !mem_store;
        end else if (flow_hit) begin
            issue_eu_o             = flow_eu;
            issue_eu_ctl_o.bu      = flow_ctl;
            issue_rs1_req_o        = flow_rs1_req;
            issue_rs2_req_o        = flow_rs2_req;
            issue_imm_req_o        = 1'b1;
            issue_res_ready_o      = flow_res_ready;
            issue_stall_possible_o = flow_stall_possible;
            issue_regstat_upd_o    = flow_regstat_upd;
        end else if (sys_hit) begin
            issue_except_raised_o  = sys_except_raised;
            issue_except_code_o    = sys_except_code;
            issue_res_ready_o      = sys_res_ready;
            issue_stall_possible_o = 1'b1;
            issue_regstat_upd_o    = sys_regstat_upd;
        end else begin
            issue_except_raised_o  = 1'b1;
            issue_except_code_o    = E_ILLEGAL_INSTRUCTION;
        end
    end

endmodule

//--- system_op_decoder.sv
// ========================================
// System class of the issue decoder
// CSR access, fences, environment calls and returns
// ========================================
`timescale 1ns/1ps

module system_op_decoder (
    input  logic [issue_pkg::ILEN-1:0] issue_instruction_i,
    output logic                       sys_hit_o,
    output logic                       sys_regstat_upd_o,
    output logic                       sys_res_ready_o,
    output logic                       sys_except_raised_o,
    output issue_pkg::except_code_t    sys_except_code_o
);
    import issue_pkg::*;

    logic [OPCODE_LEN-1:0]  opcode;
    logic [FUNCT3_LEN-1:0]  funct3;
    logic [FUNCT7_LEN-1:0]  funct7;
    logic [I_IMM-1:0]       imm;
    logic [REG_IDX_LEN-1:0] rs1;
    logic [REG_IDX_LEN-1:0] rd;
    logic                   is_csr;
    logic                   priv_base;
    logic                   is_ret_env;
    logic                   is_ebreak;
    logic                   is_sfence;
    logic                   is_fence;
    logic                   is_fence_i;

    assign opcode = issue_instruction_i[OPCODE_LEN-1:0];
    assign funct3 = issue_instruction_i[14 -: FUNCT3_LEN];
    assign funct7 = issue_instruction_i[31 -: FUNCT7_LEN];
    assign imm    = issue_instruction_i[31 -: I_IMM];
    assign rs1    = issue_instruction_i[19 -: REG_IDX_LEN];
    assign rd     = issue_instruction_i[11 -: REG_IDX_LEN];

    assign is_csr = (opcode == SYSTEM) &&
                    (funct3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI});

    // Privileged group needs rs1 and rd cleared
    assign priv_base  = (opcode == SYSTEM) && (funct3 == F3_PRIV) && (rs1 == '0) && (rd == '0);
    assign is_ebreak  = priv_base && (imm == EBREAK_IMM);
    assign is_ret_env = priv_base && (imm inside {ECALL_IMM, MRET_IMM, SRET_IMM, WFI_IMM});

    // rs1 and rs2 carry the address and ASID
    assign is_sfence = (opcode == SYSTEM) && (funct3 == F3_PRIV) &&
                       (funct7 == SFENCE_VMA_F7) && (rd == '0);

    assign is_fence   = (opcode == MISC_MEM) && (funct3 == F3_FENCE) &&
                        (issue_instruction_i[31 -: 4] == FENCE_FM) && (rs1 == '0) && (rd == '0);
    assign is_fence_i = (opcode == MISC_MEM) && (funct3 == F3_FENCE_I) &&
                        (imm == FENCE_I_IMM) && (rs1 == '0) && (rd == '0);

    assign sys_hit_o = is_csr || is_ebreak || is_ret_env || is_sfence || is_fence || is_fence_i;

    assign sys_regstat_upd_o   = is_csr;
    assign sys_res_ready_o     = sys_hit_o && !is_ebreak;
    assign sys_except_raised_o = is_ebreak;
    assign sys_except_code_o   = is_ebreak ? E_BREAKPOINT : E_UNKNOWN;

endmodule

//--- flow_op_decoder.sv
// ========================================
// Control-flow class of the issue decoder
// Branches, jumps and the upper-immediate instructions
// ========================================
`timescale 1ns/1ps

module flow_op_decoder (
    input  logic [issue_pkg::ILEN-1:0] issue_instruction_i,
    output logic                       flow_hit_o,
    output issue_pkg::issue_eu_t       flow_eu_o,
    output issue_pkg::bu_ctl_t         flow_ctl_o,
    output logic                       flow_rs1_req_o,
    output logic                       flow_rs2_req_o,
    output logic                       flow_res_ready_o,
    output logic                       flow_stall_possible_o,
    output logic                       flow_regstat_upd_o
);
    import issue_pkg::*;

    logic [OPCODE_LEN-1:0] opcode;
    logic [FUNCT3_LEN-1:0] funct3;
    logic                  is_branch;
    logic                  is_jalr;
    logic                  is_link;

    assign opcode = issue_instruction_i[OPCODE_LEN-1:0];
    assign funct3 = issue_instruction_i[14 -: FUNCT3_LEN];

    // funct3 2 and 3 are reserved for BRANCH
    assign is_branch = (opcode == BRANCH) && (funct3[2:1] != 2'b01);
    assign is_jalr   = (opcode == JALR) && (funct3 == F3_JALR);

    // Result computed at issue, no unit involved
    assign is_link = is_jalr || (opcode == JAL) || (opcode == LUI) || (opcode == AUIPC);

    always_comb begin
        flow_eu_o  = EU_NONE;
        flow_ctl_o = BEQ;
        if (is_branch) begin
            flow_eu_o  = EU_BRANCH_UNIT;
            flow_ctl_o = bu_ctl_t'({{(EU_CTL_W-FUNCT3_LEN){1'b0}}, funct3});
        end
    end

    assign flow_hit_o            = is_branch || is_link;
    assign flow_rs1_req_o        = is_branch;
    assign flow_rs2_req_o        = is_branch;
    assign flow_res_ready_o      = is_link;
    assign flow_stall_possible_o = is_jalr;
    assign flow_regstat_upd_o    = is_link;

endmodule

//--- mem_op_decoder.sv
// ========================================
// Load/store class of the issue decoder
// Reports a hit, load or store, and the access width
// ========================================
`timescale 1ns/1ps

module mem_op_decoder (
    input  logic [issue_pkg::ILEN-1:0] issue_instruction_i,
    output logic                       mem_hit_o,
    output logic                       mem_store_o,
    output issue_pkg::ls_ctl_t         mem_ctl_o
);
    import issue_pkg::*;

    logic [OPCODE_LEN-1:0] opcode;
    logic [FUNCT3_LEN-1:0] funct3;
    logic                  is_load;
    logic                  is_store;
    ls_ctl_t               width;

    assign opcode = issue_instruction_i[OPCODE_LEN-1:0];
    assign funct3 = issue_instruction_i[14 -: FUNCT3_LEN];

    // No unsigned stores, and no 64-bit unsigned load
    assign is_load  = (opcode == LOAD) && (funct3 != 3'd7);
    assign is_store = (opcode == STORE) && !funct3[2];

    always_comb begin
        width = LS_BYTE;
        case (funct3)
            F3_B:    width = LS_BYTE;
            F3_H:    width = LS_HALFWORD;
            F3_W:    width = LS_WORD;
            F3_D:    width = LS_DOUBLEWORD;
            F3_BU:   width = LS_BYTE_U;
            F3_HU:   width = LS_HALFWORD_U;
            F3_WU:   width = LS_WORD_U;
            default: width = LS_BYTE;
        endcase
    end

    assign mem_hit_o   = is_load || is_store;
    assign mem_store_o = is_store;
    assign mem_ctl_o   = mem_hit_o ? width : LS_BYTE;

endmodule

//--- alu_op_decoder.sv
// ========================================
// Integer ALU class of the issue decoder
// Register and immediate forms, 64-bit and word variants
// ========================================
`timescale 1ns/1ps

module alu_op_decoder (
    input  logic [issue_pkg::ILEN-1:0] issue_instruction_i,
    output logic                       alu_hit_o,
    output issue_pkg::alu_ctl_t        alu_ctl_o,
    output logic                       alu_rs2_req_o,
    output issue_pkg::imm_format_t     alu_imm_format_o
);
    import issue_pkg::*;

    logic [OPCODE_LEN-1:0] opcode;
    logic [FUNCT3_LEN-1:0] funct3;
    logic [FUNCT7_LEN-1:0] funct7;
    logic                  reg_form;
    logic                  imm_form;
    logic                  word_form;
    logic                  arith;
    logic                  f3_ok;
    logic                  f7_ok;
    logic                  is_shift;
    alu_ctl_t              op;

    assign opcode = issue_instruction_i[OPCODE_LEN-1:0];
    assign funct3 = issue_instruction_i[14 -: FUNCT3_LEN];
    assign funct7 = issue_instruction_i[31 -: FUNCT7_LEN];

    assign reg_form  = (opcode == OP) || (opcode == OP_32);
    assign imm_form  = (opcode == OP_IMM) || (opcode == OP_IMM_32);
    assign word_form = (opcode == OP_32) || (opcode == OP_IMM_32);
    // Bit 30 selects SUB and the arithmetic shifts
    assign arith     = issue_instruction_i[30];
    assign is_shift  = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    // Word forms only exist for add/sub and shifts
    assign f3_ok = !word_form || (funct3 inside {F3_ADD_SUB, F3_SLL, F3_SRL_SRA});
    assign f7_ok = !reg_form || (funct7 == F7_BASE) ||
                   ((funct7 == F7_ALT) && ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));

    assign alu_hit_o = (reg_form || imm_form) && f3_ok && f7_ok;

    always_comb begin
        op = ADD;
        case (funct3)
            F3_ADD_SUB: begin
                if (reg_form && arith) begin
                    op = word_form ? SUBW : SUB;
                end else begin
                    op = word_form ? ADDW : ADD;
                end
            end
            F3_SLL:  op = word_form ? SLLW : SLL;
            F3_SLT:  op = SLT;
            F3_SLTU: op = SLTU;
            F3_XOR:  op = XOR;
            F3_SRL_SRA: begin
                if (arith) begin
                    op = word_form ? SRAW : SRA;
                end else begin
                    op = word_form ? SRLW : SRL;
                end
            end
            F3_OR:   op = OR;
            F3_AND:  op = AND;
        endcase
    end

    assign alu_ctl_o        = alu_hit_o ? op : ADD;
    assign alu_rs2_req_o    = alu_hit_o && reg_form;
    assign alu_imm_format_o = (alu_hit_o && imm_form && is_shift) ? IMM_SHAMT : IMM_SEXT;

endmodule

//--- issue_pkg.sv
// ========================================
// Shared definitions for the issue-stage decoder
// Field widths, RV64I encodings and the decode result types
// ========================================
package issue_pkg;

    // Field widths
    localparam int unsigned ILEN        = 32;
    localparam int unsigned REG_IDX_LEN = 5;
    localparam int unsigned OPCODE_LEN  = 7;
    localparam int unsigned FUNCT3_LEN  = 3;
    localparam int unsigned FUNCT7_LEN  = 7;
    localparam int unsigned I_IMM       = 12;
    localparam int unsigned EU_CTL_W    = 8;

    // Major opcodes
    localparam logic [OPCODE_LEN-1:0] OP        = 7'b0110011;
    localparam logic [OPCODE_LEN-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_LEN-1:0] OP_32     = 7'b0111011;
    localparam logic [OPCODE_LEN-1:0] OP_IMM_32 = 7'b0011011;
    localparam logic [OPCODE_LEN-1:0] LOAD      = 7'b0000011;
    localparam logic [OPCODE_LEN-1:0] STORE     = 7'b0100011;
    localparam logic [OPCODE_LEN-1:0] BRANCH    = 7'b1100011;
    localparam logic [OPCODE_LEN-1:0] JAL       = 7'b1101111;
    localparam logic [OPCODE_LEN-1:0] JALR      = 7'b1100111;
    localparam logic [OPCODE_LEN-1:0] LUI       = 7'b0110111;
    localparam logic [OPCODE_LEN-1:0] AUIPC     = 7'b0010111;
    localparam logic [OPCODE_LEN-1:0] MISC_MEM  = 7'b0001111;
    localparam logic [OPCODE_LEN-1:0] SYSTEM    = 7'b1110011;

    // Integer ALU funct3 / funct7
    localparam logic [FUNCT3_LEN-1:0] F3_ADD_SUB = 3'd0;
    localparam logic [FUNCT3_LEN-1:0] F3_SLL     = 3'd1;
    localparam logic [FUNCT3_LEN-1:0] F3_SLT     = 3'd2;
    localparam logic [FUNCT3_LEN-1:0] F3_SLTU    = 3'd3;
    localparam logic [FUNCT3_LEN-1:0] F3_XOR     = 3'd4;
    localparam logic [FUNCT3_LEN-1:0] F3_SRL_SRA = 3'd5;
    localparam logic [FUNCT3_LEN-1:0] F3_OR      = 3'd6;
    localparam logic [FUNCT3_LEN-1:0] F3_AND     = 3'd7;
    localparam logic [FUNCT7_LEN-1:0] F7_BASE    = 7'b0000000;
    localparam logic [FUNCT7_LEN-1:0] F7_ALT     = 7'b0100000;

    // Load/store access width in funct3
    localparam logic [FUNCT3_LEN-1:0] F3_B  = 3'd0;
    localparam logic [FUNCT3_LEN-1:0] F3_H  = 3'd1;
    localparam logic [FUNCT3_LEN-1:0] F3_W  = 3'd2;
    localparam logic [FUNCT3_LEN-1:0] F3_D  = 3'd3;
    localparam logic [FUNCT3_LEN-1:0] F3_BU = 3'd4;
    localparam logic [FUNCT3_LEN-1:0] F3_HU = 3'd5;
    localparam logic [FUNCT3_LEN-1:0] F3_WU = 3'd6;

    localparam logic [FUNCT3_LEN-1:0] F3_JALR = 3'd0;

    // SYSTEM and MISC_MEM funct3
    localparam logic [FUNCT3_LEN-1:0] F3_PRIV    = 3'd0;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRW   = 3'd1;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRS   = 3'd2;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRC   = 3'd3;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRWI  = 3'd5;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRSI  = 3'd6;
    localparam logic [FUNCT3_LEN-1:0] F3_CSRRCI  = 3'd7;
    localparam logic [FUNCT3_LEN-1:0] F3_FENCE   = 3'd0;
    localparam logic [FUNCT3_LEN-1:0] F3_FENCE_I = 3'd1;

    // Fixed fields, imm is funct7 and rs2 together
    localparam logic [I_IMM-1:0]      ECALL_IMM     = 12'h000;
    localparam logic [I_IMM-1:0]      EBREAK_IMM    = 12'h001;
    localparam logic [I_IMM-1:0]      SRET_IMM      = 12'h102;
    localparam logic [I_IMM-1:0]      WFI_IMM       = 12'h105;
    localparam logic [I_IMM-1:0]      MRET_IMM      = 12'h302;
    localparam logic [I_IMM-1:0]      FENCE_I_IMM   = 12'h000;
    localparam logic [3:0]            FENCE_FM      = 4'b0000;
    localparam logic [FUNCT7_LEN-1:0] SFENCE_VMA_F7 = 7'b0001001;

    typedef enum logic [2:0] {
        EU_NONE, EU_INT_ALU, EU_LOAD_BUFFER, EU_STORE_BUFFER, EU_BRANCH_UNIT
    } issue_eu_t;

    typedef enum logic [EU_CTL_W-1:0] {
        ADD, ADDW, SUB, SUBW, AND, OR, XOR, SLL, SLLW, SRL, SRLW, SRA, SRAW, SLT, SLTU
    } alu_ctl_t;

    typedef enum logic [EU_CTL_W-1:0] {
        LS_BYTE, LS_BYTE_U, LS_HALFWORD, LS_HALFWORD_U, LS_WORD, LS_WORD_U, LS_DOUBLEWORD
    } ls_ctl_t;

    // Same codes as the BRANCH funct3 field
    typedef enum logic [EU_CTL_W-1:0] {
        BEQ = 8'd0, BNE = 8'd1, BLT = 8'd4, BGE = 8'd5, BLTU = 8'd6, BGEU = 8'd7
    } bu_ctl_t;

    // One control word, read according to the assigned unit
    typedef union packed {
        alu_ctl_t alu;
        ls_ctl_t  ls;
        bu_ctl_t  bu;
    } eu_ctl_t;

    typedef enum logic {IMM_SEXT, IMM_SHAMT} imm_format_t;

    typedef enum logic [3:0] {
        E_ILLEGAL_INSTRUCTION = 4'd2,
        E_BREAKPOINT          = 4'd3,
        E_UNKNOWN             = 4'd15
    } except_code_t;

endpackage
